/* common/mx_pkg.sv */
package mx_pkg;

    // ========================================
    // MXINT8 block format
    // ========================================
    localparam int ELEMENT_WIDTH   = 8;
    localparam int SCALE_WIDTH     = 8;
    localparam int SCALE_SUM_WIDTH = SCALE_WIDTH + 1;   // scale_a + scale_b
    localparam int PRODUCT_WIDTH   = 2 * ELEMENT_WIDTH;

    typedef logic signed [ELEMENT_WIDTH-1:0] mx_element_t;
    typedef logic [SCALE_WIDTH-1:0]          mx_scale_t;

    // reserved codes
    localparam mx_scale_t   SCALE_NAN      = 8'd255;
    localparam mx_element_t ELEMENT_UNUSED = 8'h80;

    // ========================================
    // FP32 result format
    // ========================================
    localparam int FP32_EXP_WIDTH  = 8;
    localparam int FP32_FRAC_WIDTH = 23;

    typedef struct packed {
        logic                       sign;
        logic [FP32_EXP_WIDTH-1:0]  exponent;
        logic [FP32_FRAC_WIDTH-1:0] fraction;
    } fp32_t;

    localparam logic [FP32_EXP_WIDTH-1:0]  FP32_EXP_MAX   = 8'hff;
    localparam logic [FP32_FRAC_WIDTH-1:0] FP32_QNAN_FRAC = 23'h40_0000;

    // position of the leading one inside the block sum
    localparam int LEAD_POS_WIDTH = 6;

    // ========================================
    // exponent arithmetic
    // ========================================
    // element scaling 2^-12 and two scale biases of 127 give
    // biased exp = lead_pos + scale_sum - 266 + 127
    localparam int EXP_OFFSET = 139;

    // subnormal fraction = magnitude * 2^(scale_sum - 117)
    localparam logic [SCALE_SUM_WIDTH-1:0] SUBNORMAL_OFFSET = 9'd117;

    // ========================================
    // sideband carried next to the sum
    // ========================================
    typedef struct packed {
        logic [SCALE_SUM_WIDTH-1:0] scale_sum;
        logic                       is_nan;
        logic                       is_unused;
    } mx_side_t;

endpackage

/* dot_product/mx_product_tree.sv */
module mx_product_tree #(
    parameter int BLOCK_SIZE = 32,
    parameter int SUM_WIDTH  = 21
) (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    input  logic                                   i_valid,
    input  mx_pkg::mx_element_t [BLOCK_SIZE-1:0]   i_elements_a,
    input  mx_pkg::mx_element_t [BLOCK_SIZE-1:0]   i_elements_b,
    output logic                                   o_valid,
    output logic signed [SUM_WIDTH-1:0]            o_sum
);

    localparam int NODE_COUNT = 2 * BLOCK_SIZE - 1;

    logic signed [mx_pkg::PRODUCT_WIDTH-1:0] product_q [BLOCK_SIZE];
    logic signed [SUM_WIDTH-1:0]             tree_node [NODE_COUNT];
    logic                                    product_valid_q;

    // ========================================
    // stage 1: element products
    // ========================================
    always_ff @(posedge i_clk) begin
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            product_q[i] <= $signed(i_elements_a[i]) * $signed(i_elements_b[i]);
        end
    end

    // ========================================
    // stage 2: adder tree
    // ========================================
    // heap layout, node k sums children 2k+1 and 2k+2
    // leaves sit at BLOCK_SIZE-1 .. NODE_COUNT-1
    genvar g;
    generate
        for (g = 0; g < BLOCK_SIZE; g++) begin : g_leaf
            assign tree_node[BLOCK_SIZE-1+g] = SUM_WIDTH'(product_q[g]);   // sign extend
        end
        for (g = 0; g < BLOCK_SIZE - 1; g++) begin : g_node
            assign tree_node[g] = tree_node[2*g+1] + tree_node[2*g+2];
        end
    endgenerate

    always_ff @(posedge i_clk) begin
        o_sum <= tree_node[0];
    end

    // valid follows the data through both stages
    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            product_valid_q <= 1'b0;
            o_valid         <= 1'b0;
        end else begin
            product_valid_q <= i_valid;
            o_valid         <= product_valid_q;
        end
    end

endmodule

/* fp32_encode/fp32_normalizer.sv */
module fp32_normalizer #(
    parameter int SUM_WIDTH = 21
) (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic                                  i_valid,
    input  logic signed [SUM_WIDTH-1:0]           i_sum,
    input  mx_pkg::mx_side_t                      i_side,
    output logic                                  o_valid,
    output mx_pkg::mx_side_t                      o_side,
    output logic                                  o_sign,
    output logic                                  o_is_zero,
    output logic [mx_pkg::LEAD_POS_WIDTH-1:0]     o_lead_pos,
    output logic [SUM_WIDTH-1:0]                  o_magnitude,
    output logic [mx_pkg::FP32_FRAC_WIDTH-1:0]    o_fraction
);

    localparam int FRAC_WIDTH = mx_pkg::FP32_FRAC_WIDTH;
    localparam int JUST_WIDTH = SUM_WIDTH + FRAC_WIDTH;

    logic                               sign;
    logic [SUM_WIDTH-1:0]               magnitude;
    logic [mx_pkg::LEAD_POS_WIDTH-1:0]  lead_pos;
    logic [JUST_WIDTH-1:0]              justified;

    assign sign      = i_sum[SUM_WIDTH-1];
    assign magnitude = sign ? -i_sum : i_sum;   // most negative sum never reached

    // priority search, highest set bit wins
    always_comb begin
        lead_pos = '0;
        for (int i = 0; i < SUM_WIDTH; i++) begin
            if (magnitude[i]) begin
                lead_pos = mx_pkg::LEAD_POS_WIDTH'(i);
            end
        end
    end

    // leading one lands on bit FRAC_WIDTH and drops out of the fraction
    assign justified = {magnitude, {FRAC_WIDTH{1'b0}}} >> lead_pos;

    always_ff @(posedge i_clk) begin
        o_side      <= i_side;
        o_sign      <= sign;
        o_is_zero   <= (magnitude == '0);
        o_lead_pos  <= lead_pos;
        o_magnitude <= magnitude;
        o_fraction  <= justified[FRAC_WIDTH-1:0];
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

endmodule

/* fp32_encode/fp32_packer.sv */
module fp32_packer #(
    parameter int SUM_WIDTH = 21
) (
    input  logic                                  i_clk,
    input  logic                                  i_reset,
    input  logic                                  i_valid,
    input  mx_pkg::mx_side_t                      i_side,
    input  logic                                  i_sign,
    input  logic                                  i_is_zero,
    input  logic [mx_pkg::LEAD_POS_WIDTH-1:0]     i_lead_pos,
    input  logic [SUM_WIDTH-1:0]                  i_magnitude,
    input  logic [mx_pkg::FP32_FRAC_WIDTH-1:0]    i_fraction,
    output logic                                  o_valid,
    output mx_pkg::fp32_t                         o_result,
    output logic                                  o_overflow,
    output logic                                  o_is_nan,
    output logic                                  o_is_unused
);

    localparam int FRAC_WIDTH     = mx_pkg::FP32_FRAC_WIDTH;
    localparam int WIDE_WIDTH     = SUM_WIDTH + FRAC_WIDTH;
    localparam int EXP_CALC_WIDTH = 11;
    localparam logic signed [EXP_CALC_WIDTH-1:0] EXP_LIMIT =
        EXP_CALC_WIDTH'(mx_pkg::FP32_EXP_MAX);

    logic signed [EXP_CALC_WIDTH-1:0]      exp_biased;
    logic [mx_pkg::SCALE_SUM_WIDTH-1:0]    sub_left;
    logic [mx_pkg::SCALE_SUM_WIDTH-1:0]    sub_right;
    logic [WIDE_WIDTH-1:0]                 sub_wide;
    mx_pkg::fp32_t                         result_d;
    logic                                  overflow_d;

    // wraps modulo 2^11, read back as signed
    assign exp_biased = EXP_CALC_WIDTH'(i_lead_pos) + EXP_CALC_WIDTH'(i_side.scale_sum)
                      - EXP_CALC_WIDTH'(mx_pkg::EXP_OFFSET);

    // ========================================
    // subnormal fraction
    // ========================================
    assign sub_left  = i_side.scale_sum - mx_pkg::SUBNORMAL_OFFSET;
    assign sub_right = mx_pkg::SUBNORMAL_OFFSET - i_side.scale_sum;

    always_comb begin
        if (i_side.scale_sum >= mx_pkg::SUBNORMAL_OFFSET) begin
            sub_wide = WIDE_WIDTH'(i_magnitude) << sub_left;
        end else begin
            sub_wide = WIDE_WIDTH'(i_magnitude) >> sub_right;  // truncates
        end
    end

    // ========================================
    // encode
    // ========================================
    always_comb begin
        result_d   = '0;
        overflow_d = 1'b0;
        if (i_side.is_nan) begin
            result_d.exponent = mx_pkg::FP32_EXP_MAX;
            result_d.fraction = mx_pkg::FP32_QNAN_FRAC;
        end else if (i_is_zero) begin
            result_d = '0;                      // always +0
        end else if (exp_biased >= EXP_LIMIT) begin
            result_d.sign     = i_sign;
            result_d.exponent = mx_pkg::FP32_EXP_MAX;
            overflow_d        = 1'b1;
        end else if (exp_biased <= 0) begin
            result_d.sign     = i_sign;
            result_d.fraction = sub_wide[FRAC_WIDTH-1:0];
        end else begin
            result_d.sign     = i_sign;
            result_d.exponent = exp_biased[mx_pkg::FP32_EXP_WIDTH-1:0];
            result_d.fraction = i_fraction;
        end
    end

    always_ff @(posedge i_clk) begin
        o_result    <= result_d;
        o_overflow  <= overflow_d;
        o_is_nan    <= i_side.is_nan;
        o_is_unused <= i_side.is_unused;
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            o_valid <= 1'b0;
        end else begin
            o_valid <= i_valid;
        end
    end

endmodule

/* mxint8_dot_product.f */
+incdir+verification
common/mx_pkg.sv
dot_product/mx_product_tree.sv
rtl/mx_block_classify.sv
fp32_encode/fp32_normalizer.sv
fp32_encode/fp32_packer.sv
rtl/mxint8_dot_product.sv
verification/tb_mxint8_dot_product.sv

/* rtl/mx_block_classify.sv */
module mx_block_classify #(
    parameter int BLOCK_SIZE = 32
) (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    input  logic                                   i_valid,
    input  mx_pkg::mx_scale_t                      i_scale_a,
    input  mx_pkg::mx_scale_t                      i_scale_b,
    input  mx_pkg::mx_element_t [BLOCK_SIZE-1:0]   i_elements_a,
    input  mx_pkg::mx_element_t [BLOCK_SIZE-1:0]   i_elements_b,
    output mx_pkg::mx_side_t                       o_side
);

    mx_pkg::mx_side_t side_d;
    mx_pkg::mx_side_t side_q;
    logic             side_valid_q;

    always_comb begin
        side_d.scale_sum = mx_pkg::SCALE_SUM_WIDTH'(i_scale_a)
                         + mx_pkg::SCALE_SUM_WIDTH'(i_scale_b);
        side_d.is_nan    = (i_scale_a == mx_pkg::SCALE_NAN) || (i_scale_b == mx_pkg::SCALE_NAN);
        side_d.is_unused = 1'b0;
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            if (i_elements_a[i] == mx_pkg::ELEMENT_UNUSED ||
                i_elements_b[i] == mx_pkg::ELEMENT_UNUSED) begin
                side_d.is_unused = 1'b1;
            end
        end
    end

    // two stages to line up with the product tree
    always_ff @(posedge i_clk) begin
        if (i_valid) begin
            side_q <= side_d;
        end
        if (side_valid_q) begin
            o_side <= side_q;
        end
    end

    always_ff @(posedge i_clk) begin
        if (i_reset) begin
            side_valid_q <= 1'b0;
        end else begin
            side_valid_q <= i_valid;
        end
    end

endmodule

/* rtl/mxint8_dot_product.sv */
module mxint8_dot_product #(
    parameter int BLOCK_SIZE = 32
) (
    input  logic                                   i_clk,
    input  logic                                   i_reset,
    input  logic                                   i_valid,
    input  mx_pkg::mx_scale_t                      i_scale_a,
    input  mx_pkg::mx_scale_t                      i_scale_b,
    input  mx_pkg::mx_element_t [BLOCK_SIZE-1:0]   i_elements_a,
    input  mx_pkg::mx_element_t [BLOCK_SIZE-1:0]   i_elements_b,
    output logic                                   o_valid,
    output mx_pkg::fp32_t                          o_result,
    output logic                                   o_overflow,
    output logic                                   o_is_nan,
    output logic                                   o_is_unused
);

    // 15 magnitude bits per product, log2 growth in the tree, one sign bit
    localparam int SUM_WIDTH = 15 + $clog2(BLOCK_SIZE) + 1;

    logic                                tree_valid;
    logic signed [SUM_WIDTH-1:0]         tree_sum;
    mx_pkg::mx_side_t                    class_side;
    logic                                norm_valid;
    mx_pkg::mx_side_t                    norm_side;
    logic                                norm_sign;
    logic                                norm_is_zero;
    logic [mx_pkg::LEAD_POS_WIDTH-1:0]   norm_lead_pos;
    logic [SUM_WIDTH-1:0]                norm_magnitude;
    logic [mx_pkg::FP32_FRAC_WIDTH-1:0]  norm_fraction;

    // ========================================
    // stages 1-2
    // ========================================
    mx_product_tree #(.BLOCK_SIZE(BLOCK_SIZE), .SUM_WIDTH(SUM_WIDTH)) u_product_tree (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_elements_a (i_elements_a),
        .i_elements_b (i_elements_b),
        .o_valid      (tree_valid),
        .o_sum        (tree_sum)
    );

    mx_block_classify #(.BLOCK_SIZE(BLOCK_SIZE)) u_block_classify (
        .i_clk        (i_clk),
        .i_reset      (i_reset),
        .i_valid      (i_valid),
        .i_scale_a    (i_scale_a),
        .i_scale_b    (i_scale_b),
        .i_elements_a (i_elements_a),
        .i_elements_b (i_elements_b),
        .o_side       (class_side)
    );

    // ========================================
    // stages 3-4
    // ========================================
    fp32_normalizer #(.SUM_WIDTH(SUM_WIDTH)) u_normalizer (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_valid     (tree_valid),
        .i_sum       (tree_sum),
        .i_side      (class_side),
        .o_valid     (norm_valid),
        .o_side      (norm_side),
        .o_sign      (norm_sign),
        .o_is_zero   (norm_is_zero),
        .o_lead_pos  (norm_lead_pos),
        .o_magnitude (norm_magnitude),
        .o_fraction  (norm_fraction)
    );

    fp32_packer #(.SUM_WIDTH(SUM_WIDTH)) u_packer (
        .i_clk       (i_clk),
        .i_reset     (i_reset),
        .i_valid     (norm_valid),
        .i_side      (norm_side),
        .i_sign      (norm_sign),
        .i_is_zero   (norm_is_zero),
        .i_lead_pos  (norm_lead_pos),
        .i_magnitude (norm_magnitude),
        .i_fraction  (norm_fraction),
        .o_valid     (o_valid),
        .o_result    (o_result),
        .o_overflow  (o_overflow),
        .o_is_nan    (o_is_nan),
        .o_is_unused (o_is_unused)
    );

endmodule

/* verification/mx_ref_model.svh */
`ifndef MX_REF_MODEL_SVH
`define MX_REF_MODEL_SVH

// expected word and flags for one block pair
typedef struct packed {
    mx_pkg::fp32_t result;
    logic          overflow;
    logic          is_nan;
    logic          is_unused;
} expected_t;

// ========================================
// value = S * 2^(ss - 266)
// ========================================
function automatic expected_t model_block(
    input mx_pkg::mx_scale_t                    scale_a,
    input mx_pkg::mx_scale_t                    scale_b,
    input mx_pkg::mx_element_t [BLOCK_SIZE-1:0] elements_a,
    input mx_pkg::mx_element_t [BLOCK_SIZE-1:0] elements_b
);
    expected_t expected;
    longint    sum;
    longint    mag;
    int        scale_sum;
    int        msb;
    int        exp_unbiased;
    int        shift;
    expected  = '0;
    sum       = 0;
    scale_sum = int'(scale_a) + int'(scale_b);
    for (int i = 0; i < BLOCK_SIZE; i++) begin
        sum += longint'($signed(elements_a[i])) * longint'($signed(elements_b[i]));
        if (elements_a[i] == mx_pkg::ELEMENT_UNUSED || elements_b[i] == mx_pkg::ELEMENT_UNUSED) begin
            expected.is_unused = 1'b1;   // still counted in the sum
        end
    end
    if (scale_a == 8'd255 || scale_b == 8'd255) begin
        expected.is_nan = 1'b1;
        expected.result = 32'h7fc0_0000;
        return expected;
    end
    if (sum == 0) begin
        return expected;                 // +0
    end
    mag = (sum < 0) ? -sum : sum;
    msb = 0;
    while ((mag >> (msb + 1)) != 0) begin
        msb++;
    end
    exp_unbiased         = msb + scale_sum - 266;
    expected.result.sign = (sum < 0);
    if (exp_unbiased > 127) begin
        expected.result.exponent = 8'hff;
        expected.overflow        = 1'b1;
    end else if (exp_unbiased < -126) begin
        // count in units of 2^-149, the smallest subnormal
        shift = scale_sum - 266 + 149;
        if (shift >= 0) begin
            expected.result.fraction = 23'(mag << shift);
        end else begin
            expected.result.fraction = 23'(mag >> (-shift));
        end
    end else begin
        expected.result.exponent = 8'(exp_unbiased + 127);
        expected.result.fraction = 23'((mag - (64'sd1 << msb)) << (23 - msb));
    end
    return expected;
endfunction

`endif

/* verification/tb_mxint8_dot_product.sv */
module tb_mxint8_dot_product;
    timeunit 1ns;
    timeprecision 1ps;

    localparam int BLOCK_SIZE   = 32;
    localparam int VECTOR_COUNT = 1200;
    localparam int RESET_CYCLES = 16;
    localparam int LATENCY      = 4;
    localparam int MODE_COUNT   = 6;   // normal, nan, overflow, zero, subnormal, unused

    `include "mx_ref_model.svh"

    typedef struct packed {
        expected_t   response;
        logic [31:0] drive_edge;       // edge count once i_valid is driven high
    } pending_t;

    logic                                 clk;
    logic                                 reset;
    logic                                 in_valid;
    mx_pkg::mx_scale_t                    scale_a;
    mx_pkg::mx_scale_t                    scale_b;
    mx_pkg::mx_element_t [BLOCK_SIZE-1:0] elements_a;
    mx_pkg::mx_element_t [BLOCK_SIZE-1:0] elements_b;
    logic                                 out_valid;
    mx_pkg::fp32_t                        result;
    logic                                 overflow;
    logic                                 is_nan;
    logic                                 is_unused;

    pending_t    pending_q[$];
    logic [31:0] edge_count = '0;
    int          checked_count = 0;

    mxint8_dot_product #(.BLOCK_SIZE(BLOCK_SIZE)) uut (
        .i_clk        (clk),
        .i_reset      (reset),
        .i_valid      (in_valid),
        .i_scale_a    (scale_a),
        .i_scale_b    (scale_b),
        .i_elements_a (elements_a),
        .i_elements_b (elements_b),
        .o_valid      (out_valid),
        .o_result     (result),
        .o_overflow   (overflow),
        .o_is_nan     (is_nan),
        .o_is_unused  (is_unused)
    );

    initial begin
        clk = 1'b0;
        forever #5 clk = ~clk;
    end

    always @(posedge clk) begin
        edge_count <= edge_count + 1;
    end

    task automatic abort_run(input string reason);
        $display("%s", reason);
        $display("TESTS FAILED");
        $fatal(1, "simulation stopped on error");
    endtask

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        if (actual !== expected) begin
            abort_run($sformatf("CHECK FAILED at %0t ns: %s, got %h, expected %h",
                                $time, what, actual, expected));
        end
    endtask

    function automatic mx_pkg::mx_element_t random_element(input int lo, input int hi);
        return mx_pkg::mx_element_t'(lo + int'($urandom_range(hi - lo)));
    endfunction

    function automatic mx_pkg::mx_scale_t random_scale(input int lo, input int hi);
        return mx_pkg::mx_scale_t'(lo + int'($urandom_range(hi - lo)));
    endfunction

    // ========================================
    // stimulus per mode
    // ========================================
    task automatic make_vector(input int mode,
                               output mx_pkg::mx_scale_t sa, output mx_pkg::mx_scale_t sb,
                               output mx_pkg::mx_element_t [BLOCK_SIZE-1:0] ea,
                               output mx_pkg::mx_element_t [BLOCK_SIZE-1:0] eb);
        int  hole;
        logic negate;
        sa = random_scale(100, 154);
        sb = random_scale(100, 154);
        for (int i = 0; i < BLOCK_SIZE; i++) begin
            ea[i] = random_element(-127, 127);
            eb[i] = random_element(-127, 127);
        end
        case (mode)
            1: begin
                for (int i = 0; i < BLOCK_SIZE; i++) begin
                    ea[i] = random_element(-128, 127);
                end
                if ($urandom_range(1) == 0) begin
                    sa = 8'd255;
                end else begin
                    sb = 8'd255;
                end
            end
            2: begin
                sa     = random_scale(230, 254);
                sb     = random_scale(230, 254);
                negate = $urandom_range(1);
                for (int i = 0; i < BLOCK_SIZE; i++) begin
                    ea[i] = random_element(90, 127);
                    eb[i] = random_element(90, 127);
                    if (negate) begin
                        ea[i] = -ea[i];   // negative infinity
                    end
                end
            end
            3: begin
                sa = random_scale(0, 254);
                sb = random_scale(0, 254);
                ea = '0;
            end
            4: begin
                // scale sum 97..120, so the fraction shifts both ways around 117
                sa = random_scale(0, 20);
                sb = random_scale(97, 100);
            end
            5: begin
                repeat (1 + $urandom_range(2)) begin
                    hole = $urandom_range(BLOCK_SIZE - 1);
                    if ($urandom_range(1) == 0) begin
                        ea[hole] = mx_pkg::ELEMENT_UNUSED;
                    end else begin
                        eb[hole] = mx_pkg::ELEMENT_UNUSED;
                    end
                end
            end
            default: ;
        endcase
    endtask

    // ========================================
    // driver
    // ========================================
    initial begin
        mx_pkg::mx_scale_t                    sa;
        mx_pkg::mx_scale_t                    sb;
        mx_pkg::mx_element_t [BLOCK_SIZE-1:0] ea;
        mx_pkg::mx_element_t [BLOCK_SIZE-1:0] eb;
        pending_t                             entry;
        int                                   sent;
        int                                   idle_slot;
        void'($urandom(32'h3a60));
        reset      = 1'b1;
        in_valid   = 1'b0;
        scale_a    = '0;
        scale_b    = '0;
        elements_a = '0;
        elements_b = '0;
        sent       = 0;
        repeat (RESET_CYCLES) @(posedge clk);
        reset <= 1'b0;
        while (sent < VECTOR_COUNT) begin
            idle_slot = $urandom_range(3);   // one idle cycle in four
            for (int slot = 0; slot < 4; slot++) begin
                @(posedge clk);
                if (slot == idle_slot || sent >= VECTOR_COUNT) begin
                    in_valid <= 1'b0;
                end else begin
                    make_vector(sent % MODE_COUNT, sa, sb, ea, eb);
                    entry.response   = model_block(sa, sb, ea, eb);
                    entry.drive_edge = edge_count + 1;   // count of this edge
                    pending_q.push_back(entry);
                    in_valid   <= 1'b1;
                    scale_a    <= sa;
                    scale_b    <= sb;
                    elements_a <= ea;
                    elements_b <= eb;
                    sent++;
                end
            end
        end
        @(posedge clk);
        in_valid <= 1'b0;
        repeat (LATENCY + 4) @(posedge clk);
        if (pending_q.size() != 0) begin
            abort_run($sformatf("%0d results never came out of the DUT", pending_q.size()));
        end else begin
            $display("TESTS PASSED");
            $finish;
        end
    end

    // ========================================
    // scoreboard, sampled mid cycle
    // ========================================
    always @(negedge clk) begin
        pending_t head;
        if (reset) begin
            check_value(out_valid, 32'd0, "o_valid during reset");
        end else if (out_valid === 1'b1) begin
            if (pending_q.size() == 0) begin
                abort_run("o_valid went high with no block waiting for a result");
            end else begin
                head = pending_q.pop_front();
                check_value(edge_count, head.drive_edge + LATENCY,
                            $sformatf("latency of block %0d", checked_count));
                check_value(result, head.response.result,
                            $sformatf("o_result of block %0d", checked_count));
                check_value(overflow, head.response.overflow,
                            $sformatf("o_overflow of block %0d", checked_count));
                check_value(is_nan, head.response.is_nan,
                            $sformatf("o_is_nan of block %0d", checked_count));
                check_value(is_unused, head.response.is_unused,
                            $sformatf("o_is_unused of block %0d", checked_count));
                checked_count++;
            end
        end else begin
            check_value(out_valid, 32'd0, "o_valid after reset");   // catches x
        end
    end

    // watchdog
    initial begin
        repeat (VECTOR_COUNT * 2 + 100) @(posedge clk);
        abort_run("timeout: the run did not finish within the expected number of cycles");
    end

endmodule
